//--- src/light_grid_pkg.sv
`default_nettype none

package light_grid_pkg;

    localparam int ROWS = 1000;
    localparam int COLS = 1000;
    localparam int POSITION_WIDTH = 12;

    // Grid memory is cut into vertical slices of RAM_DATA_WIDTH columns
    localparam int RAM_DATA_WIDTH = 32;
    localparam int RAM_INSTANCES = (COLS + RAM_DATA_WIDTH - 1) / RAM_DATA_WIDTH;
    localparam int RAM_ADDR_WIDTH = $clog2(ROWS);

    localparam int LIT_COUNT_WIDTH = $clog2(ROWS * COLS + 1); // Up to one million
    localparam int FIFO_DEPTH = 4;

    typedef enum logic [1:0] {
        TURN_OFF = 2'b00,
        TOGGLE   = 2'b01,
        TURN_ON  = 2'b11
    } operation_t;

    typedef logic [POSITION_WIDTH-1:0] position_t;

    // Corners are inclusive
    typedef struct packed {
        logic       last;
        logic       valid;  // Clear means no grid change
        operation_t operation;
        position_t  start_row;
        position_t  start_col;
        position_t  end_row;
        position_t  end_col;
    } instruction_t;

    typedef logic [LIT_COUNT_WIDTH-1:0] lit_count_t;

endpackage

`default_nettype wire

//--- src/light_display_ram.sv
`timescale 1ns/1ps
`default_nettype none

module light_display_ram #(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 32
)(
    input  wire                   clk,
    input  wire                   wea,
    input  wire  [ADDR_WIDTH-1:0] addra,
    input  wire  [DATA_WIDTH-1:0] dia,
    output logic [DATA_WIDTH-1:0] doa,
    input  wire  [ADDR_WIDTH-1:0] addrb,
    output logic [DATA_WIDTH-1:0] dob
);

logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

always_ff @(posedge clk) begin: port_a
    if (wea) begin
        mem[addra] <= dia;
        doa <= dia; // Write-first
    end else begin
        doa <= mem[addra];
    end
end

always_ff @(posedge clk) dob <= mem[addrb];

// Once the write enable has settled it must never go unknown again
wea_known: assert property (@(posedge clk) !$isunknown($past(wea)) |-> !$isunknown(wea))
    else $error("light_display_ram: wea became unknown");

endmodule

`default_nettype wire

//--- src/instr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fifo #(
    parameter int DEPTH = 4
)(
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           in_valid,
    output logic                          in_ready,
    input  wire light_grid_pkg::instruction_t in_data,
    output logic                          out_valid,
    input  wire                           out_ready,
    output light_grid_pkg::instruction_t  out_data
);

light_grid_pkg::instruction_t mem [DEPTH];
logic [$clog2(DEPTH)-1:0] rd_ptr, wr_ptr;
logic [$clog2(DEPTH+1)-1:0] count, count_next;
logic push, pop;

assign push = in_valid && in_ready;
assign pop = out_valid && out_ready;
assign out_valid = (count != '0);   // Pushed entry visible one edge later
assign out_data = mem[rd_ptr];

always_comb begin: next_occupancy
    count_next = count;
    if (push && !pop) begin
        count_next = count + 1'b1;
    end else if (!push && pop) begin
        count_next = count - 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
end

always_ff @(posedge clk) begin: pointers
    if (reset) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count <= '0;
        in_ready <= 1'b0;
    end else begin
        if (push) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
        if (pop) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
        count <= count_next;
        in_ready <= (count_next != DEPTH); // Back-pressure only when full
    end
end

// Pointers and occupancy must agree at both ends
no_push_full: assert property (@(posedge clk) disable iff (reset)
    (count == DEPTH) |-> (rd_ptr == wr_ptr) && !push)
    else $error("instr_fifo: push while full");

no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    (count == '0) |-> (rd_ptr == wr_ptr) && !pop)
    else $error("instr_fifo: pop while empty");

endmodule

`default_nettype wire

//--- src/light_display.sv
`timescale 1ns/1ps
`default_nettype none

module light_display (
    input  wire                              clk,
    input  wire                              reset,
    // Instruction stream
    input  wire                              instr_valid,
    output logic                             instr_ready,
    input  wire light_grid_pkg::instruction_t instr_data,
    // Final lit lights
    output logic                             count_done,
    output light_grid_pkg::lit_count_t       count_value
);

light_grid_pkg::instruction_t instr;
logic start_process;
logic readback_pending, update_ram_data;
logic current_op_is_last, finished_last_op;
logic [light_grid_pkg::RAM_ADDR_WIDTH-1:0] readback_addr, readback_addr_q, write_addr;
logic [light_grid_pkg::RAM_ADDR_WIDTH-1:0] sweep_addr, ram_addrb;
logic sweep_read, sweep_wrapped;
logic [1:0] sweep_delay;    // RAM read plus popcount register
light_grid_pkg::lit_count_t [light_grid_pkg::RAM_INSTANCES-1:0] slice_count;
light_grid_pkg::lit_count_t row_count, lit_total;

always_ff @(posedge clk) begin: flow_control
    if (reset) begin
        instr_ready <= 1'b0;
        start_process <= 1'b0;
        current_op_is_last <= 1'b0;
        finished_last_op <= 1'b0;
    end else begin
        start_process <= 1'b0;
        if (instr_valid && instr_ready) begin
            instr_ready <= 1'b0;
            start_process <= 1'b1;
        end else if (!readback_pending && !update_ram_data && !start_process) begin
            // Last row is written back before port B reads again
            if (current_op_is_last) begin
                finished_last_op <= 1'b1;   // Stream over so port B goes to the sweep
            end else begin
                instr_ready <= 1'b1;
            end
        end
        if (start_process && instr.last) current_op_is_last <= 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (instr_valid && instr_ready) instr <= instr_data;
end

always_ff @(posedge clk) begin: readback
    if (reset) begin
        readback_pending <= 1'b0;
        readback_addr <= '0;
        update_ram_data <= 1'b0;
    end else begin
        if (start_process) begin
            readback_pending <= 1'b1;
            readback_addr <= light_grid_pkg::RAM_ADDR_WIDTH'(instr.start_row);
        end else if (readback_pending) begin
            if (readback_addr == light_grid_pkg::RAM_ADDR_WIDTH'(instr.end_row)) begin
                readback_pending <= 1'b0;
            end else begin
                readback_addr <= readback_addr + 1'b1;
            end
        end
        update_ram_data <= readback_pending;    // Aligned with dob
    end
end

// Row address follows the data through the update pipeline
always_ff @(posedge clk) begin
    readback_addr_q <= readback_addr;
    write_addr <= readback_addr_q;
end

assign sweep_read = finished_last_op && !sweep_wrapped;
assign ram_addrb = finished_last_op ? sweep_addr : readback_addr;

for (genvar i = 0; i < light_grid_pkg::RAM_INSTANCES; i++) begin: g_slice
    logic [light_grid_pkg::RAM_DATA_WIDTH-1:0] mask, ram_dia, ram_dob;
    logic ram_wea;

    always_comb begin: build_mask
        for (int j = 0; j < light_grid_pkg::RAM_DATA_WIDTH; j++) begin
            mask[j] = (i * light_grid_pkg::RAM_DATA_WIDTH + j >= int'(instr.start_col)) &&
                      (i * light_grid_pkg::RAM_DATA_WIDTH + j <= int'(instr.end_col));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_wea <= 1'b0;
        end else begin
            ram_wea <= update_ram_data && instr.valid && (|mask);
        end
    end

    always_ff @(posedge clk) begin: apply_operation
        case (instr.operation)
            light_grid_pkg::TURN_OFF: ram_dia <= ram_dob & ~mask;
            light_grid_pkg::TOGGLE:   ram_dia <= ram_dob ^ mask;
            light_grid_pkg::TURN_ON:  ram_dia <= ram_dob | mask;
            default:                  ram_dia <= ram_dob;
        endcase
    end

    light_display_ram #(
        .ADDR_WIDTH(light_grid_pkg::RAM_ADDR_WIDTH),
        .DATA_WIDTH(light_grid_pkg::RAM_DATA_WIDTH)
    ) light_display_ram_i (
        .clk(clk),
        .wea(ram_wea),  // Port A writes the updated row back
        .addra(write_addr),
        .dia(ram_dia),
        .doa(),
        .addrb(ram_addrb),
        .dob(ram_dob)
    );

    always_ff @(posedge clk) slice_count[i] <= light_grid_pkg::lit_count_t'($countones(ram_dob));
end

always_comb begin: add_slices
    row_count = '0;
    for (int j = 0; j < light_grid_pkg::RAM_INSTANCES; j++) begin
        row_count = row_count + slice_count[j];
    end
end

always_ff @(posedge clk) begin: count_sweep
    if (reset) begin
        sweep_addr <= '0;
        sweep_wrapped <= 1'b0;
        sweep_delay <= '0;
        lit_total <= '0;
        count_done <= 1'b0;
        count_value <= '0;
    end else begin
        if (sweep_read) begin
            if (&sweep_addr) begin
                sweep_wrapped <= 1'b1;
            end else begin
                sweep_addr <= sweep_addr + 1'b1;
            end
        end
        sweep_delay <= {sweep_delay[0], sweep_read};
        if (sweep_delay[1]) lit_total <= lit_total + row_count;
        if (sweep_wrapped && !(|sweep_delay) && !count_done) begin
            count_done <= 1'b1;
            count_value <= lit_total;   // Held until reset
        end
    end
end

legal_operation: assert property (@(posedge clk) disable iff (reset)
    update_ram_data |-> instr.operation inside
        {light_grid_pkg::TURN_OFF, light_grid_pkg::TOGGLE, light_grid_pkg::TURN_ON})
    else $error("light_display: illegal operation during update");

nothing_after_last: assert property (@(posedge clk) disable iff (reset)
    current_op_is_last |-> !(instr_valid && instr_ready))
    else $error("light_display: instruction accepted after the last one");

endmodule

`default_nettype wire

//--- src/light_grid_top.sv
`timescale 1ns/1ps
`default_nettype none

module light_grid_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              in_valid,
    output logic                             in_ready,
    input  wire light_grid_pkg::instruction_t in_data,
    output logic                             count_done,
    output light_grid_pkg::lit_count_t       count_value
);

logic instr_valid, instr_ready;
light_grid_pkg::instruction_t instr_data;

// Soaks up the per-instruction stalls of the grid engine
instr_fifo #(
    .DEPTH(light_grid_pkg::FIFO_DEPTH)
) instr_fifo_i (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_data(in_data),
    .out_valid(instr_valid),
    .out_ready(instr_ready),
    .out_data(instr_data)
);

light_display light_display_i (
    .clk(clk),
    .reset(reset),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .instr_data(instr_data),
    .count_done(count_done),
    .count_value(count_value)
);

endmodule

`default_nettype wire

//--- test/tb_light_grid.sv
`timescale 1ns/1ps
`default_nettype none

module tb_light_grid;

localparam int CLK_PERIOD = 100;
localparam int unsigned RANDOM_SEED = 32'hd371_8342;
localparam int RANDOM_INSTRS = 10;
localparam int CYCLES_PER_INSTR = 1010;
localparam int CYCLES_PER_TEST = 1200;
localparam int WATCHDOG_CYCLES = 21 * CYCLES_PER_INSTR + 6 * CYCLES_PER_TEST; // 21 instructions

logic clk;
logic reset;
logic in_valid;
logic in_ready;
light_grid_pkg::instruction_t in_data;
logic count_done;
light_grid_pkg::lit_count_t count_value;

// Reference grid, kept across resets like the RAM
bit [light_grid_pkg::COLS-1:0] grid_model [light_grid_pkg::ROWS];
int test_errors;
int pass_count;
int fail_count;

light_grid_top light_grid_top_i (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_data(in_data),
    .count_done(count_done),
    .count_value(count_value)
);

initial begin: clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin: watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
end

function automatic light_grid_pkg::instruction_t make_instr(input logic last, input logic valid,
    input light_grid_pkg::operation_t op, input int sr, input int sc, input int er, input int ec);
    light_grid_pkg::instruction_t instr;
    instr.last = last;
    instr.valid = valid;
    instr.operation = op;
    instr.start_row = light_grid_pkg::position_t'(sr);
    instr.start_col = light_grid_pkg::position_t'(sc);
    instr.end_row = light_grid_pkg::position_t'(er);
    instr.end_col = light_grid_pkg::position_t'(ec);
    return instr;
endfunction

function automatic light_grid_pkg::lit_count_t rect_area(input light_grid_pkg::instruction_t i);
    return light_grid_pkg::lit_count_t'((int'(i.end_row) - int'(i.start_row) + 1) *
                                        (int'(i.end_col) - int'(i.start_col) + 1));
endfunction

function automatic light_grid_pkg::lit_count_t model_count();
    int total;
    total = 0;
    for (int r = 0; r < light_grid_pkg::ROWS; r++) total += $countones(grid_model[r]);
    return light_grid_pkg::lit_count_t'(total);
endfunction

task automatic apply_to_model(input light_grid_pkg::instruction_t instr);
    bit [light_grid_pkg::COLS-1:0] mask;
    if (instr.valid) begin
        for (int c = 0; c < light_grid_pkg::COLS; c++) begin
            mask[c] = (c >= int'(instr.start_col)) && (c <= int'(instr.end_col));
        end
        for (int r = int'(instr.start_row); r <= int'(instr.end_row); r++) begin
            case (instr.operation)
                light_grid_pkg::TURN_OFF: grid_model[r] &= ~mask;
                light_grid_pkg::TOGGLE:   grid_model[r] ^= mask;
                light_grid_pkg::TURN_ON:  grid_model[r] |= mask;
                default: ;
            endcase
        end
    end
endtask

task automatic check_count(input string name, input light_grid_pkg::lit_count_t expected,
    input light_grid_pkg::lit_count_t actual);
    if (actual !== expected) begin
        $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
        test_errors++;
    end
endtask

task automatic check_flag(input string name, input string what, input logic expected,
    input logic actual);
    if (actual !== expected) begin
        $display("%s: %s was %b but should have been %b", name, what, actual, expected);
        test_errors++;
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    test_errors = 0;
    in_valid <= 1'b0;
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
endtask

// Called on a rising edge, returns on the edge where the transfer happens
task automatic send_instr(input light_grid_pkg::instruction_t instr, input int gap);
    logic accepted;
    if (gap > 0) begin
        in_valid <= 1'b0;
        repeat (gap) @(posedge clk);
    end
    in_valid <= 1'b1;
    in_data <= instr;
    accepted = 1'b0;
    while (!accepted) begin
        @(negedge clk);
        accepted = in_ready;
        @(posedge clk);
    end
    apply_to_model(instr);
endtask

task automatic wait_done(input string name, input int instr_count);
    int limit;
    int cycles;
    in_valid <= 1'b0;
    limit = instr_count * CYCLES_PER_INSTR + CYCLES_PER_TEST;
    cycles = 0;
    @(negedge clk);
    while (!count_done && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    if (!count_done) begin
        $display("%s: count_done never rose within %0d cycles", name, limit);
        test_errors++;
    end
endtask

task automatic finish_test(input string name);
    if (test_errors == 0) begin
        pass_count++;
        $display("%s: passed", name);
    end else begin
        fail_count++;
        $display("%s: failed with %0d errors", name, test_errors);
    end
endtask

task automatic test_idle_until_last();
    logic done_seen;
    done_seen = 1'b0;
    apply_reset();
    @(negedge clk);
    check_flag("idle_until_last", "count_done after reset", 1'b0, count_done);
    check_flag("idle_until_last", "in_ready right after reset", 1'b0, in_ready);
    @(posedge clk);
    send_instr(make_instr(1'b0, 1'b1, light_grid_pkg::TURN_ON, 5, 5, 20, 70), 0);
    send_instr(make_instr(1'b0, 1'b1, light_grid_pkg::TOGGLE, 10, 40, 30, 999), 0);
    in_valid <= 1'b0;
    repeat (1100) begin // Longer than a whole sweep
        @(negedge clk);
        if (count_done) done_seen = 1'b1;
    end
    check_flag("idle_until_last", "count_done before the last instruction", 1'b0, done_seen);
    @(posedge clk);
    send_instr(make_instr(1'b1, 1'b1, light_grid_pkg::TURN_OFF, 0, 0, 999, 999), 0);
    wait_done("idle_until_last", 3);
    check_count("idle_until_last", model_count(), count_value);
    finish_test("idle_until_last");
endtask

task automatic test_single_turn_on();
    light_grid_pkg::instruction_t instr;
    instr = make_instr(1'b1, 1'b1, light_grid_pkg::TURN_ON, 10, 100, 509, 999);
    apply_reset();
    send_instr(instr, 0);
    wait_done("single_turn_on", 1);
    check_count("single_turn_on", rect_area(instr), count_value); // Grid was cleared before
    finish_test("single_turn_on");
endtask

task automatic test_overlap_sequence();
    apply_reset();
    send_instr(make_instr(1'b0, 1'b1, light_grid_pkg::TURN_ON, 0, 0, 299, 299), 0);
    send_instr(make_instr(1'b0, 1'b1, light_grid_pkg::TOGGLE, 150, 150, 449, 449), 0);
    send_instr(make_instr(1'b1, 1'b1, light_grid_pkg::TURN_OFF, 200, 0, 250, 999), 0);
    wait_done("overlap_sequence", 3);
    check_count("overlap_sequence", model_count(), count_value);
    finish_test("overlap_sequence");
endtask

task automatic test_invalid_last();
    light_grid_pkg::instruction_t on_instr;
    on_instr = make_instr(1'b0, 1'b1, light_grid_pkg::TURN_ON, 300, 31, 399, 64);
    apply_reset();
    send_instr(make_instr(1'b0, 1'b1, light_grid_pkg::TURN_OFF, 0, 0, 999, 999), 0);
    send_instr(on_instr, 0);
    send_instr(make_instr(1'b1, 1'b0, light_grid_pkg::TOGGLE, 0, 0, 999, 999), 0);
    wait_done("invalid_last", 3);
    check_count("invalid_last", rect_area(on_instr), count_value);
    finish_test("invalid_last");
endtask

task automatic test_random_stream();
    int r0, r1, c0, c1, gap;
    light_grid_pkg::operation_t op;
    apply_reset();
    for (int i = 0; i < RANDOM_INSTRS; i++) begin
        r0 = $urandom_range(light_grid_pkg::ROWS - 1, 0);
        r1 = $urandom_range(light_grid_pkg::ROWS - 1, 0);
        c0 = $urandom_range(light_grid_pkg::COLS - 1, 0);
        c1 = $urandom_range(light_grid_pkg::COLS - 1, 0);
        case ($urandom_range(2, 0))
            0: op = light_grid_pkg::TURN_OFF;
            1: op = light_grid_pkg::TOGGLE;
            default: op = light_grid_pkg::TURN_ON;
        endcase
        gap = ($urandom_range(2, 0) == 0) ? $urandom_range(4, 1) : 0;
        send_instr(make_instr(i == RANDOM_INSTRS - 1, $urandom_range(7, 0) != 0, op,
            (r0 < r1) ? r0 : r1, (c0 < c1) ? c0 : c1,
            (r0 < r1) ? r1 : r0, (c0 < c1) ? c1 : c0), gap);
    end
    wait_done("random_stream", RANDOM_INSTRS);
    check_count("random_stream", model_count(), count_value);
    finish_test("random_stream");
endtask

task automatic test_result_holds();
    light_grid_pkg::lit_count_t expected;
    apply_reset();
    send_instr(make_instr(1'b1, 1'b1, light_grid_pkg::TURN_ON, 0, 990, 9, 999), 0);
    wait_done("result_holds", 1);
    expected = model_count();
    check_count("result_holds", expected, count_value);
    @(posedge clk);
    in_valid <= 1'b1; // Extra instructions must never reach the grid
    in_data <= make_instr(1'b0, 1'b1, light_grid_pkg::TURN_ON, 0, 0, 999, 999);
    repeat (20) begin
        @(negedge clk);
        check_flag("result_holds", "count_done after the result", 1'b1, count_done);
        check_count("result_holds", expected, count_value);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    finish_test("result_holds");
endtask

initial begin: run_tests
    reset = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    pass_count = 0;
    fail_count = 0;
    test_errors = 0;
    void'($urandom(RANDOM_SEED));
    test_idle_until_last();
    test_single_turn_on();
    test_overlap_sequence();
    test_invalid_last();
    test_random_stream();
    test_result_holds();
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- light_grid.f
src/light_grid_pkg.sv
src/light_display_ram.sv
src/instr_fifo.sv
src/light_display.sv
src/light_grid_top.sv
test/tb_light_grid.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

# The grid RAM has no reset, so it starts from all zeros
verilator --binary --timing --assert -Wno-fatal --x-initial 0 \
    --top-module tb_light_grid -f light_grid.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_light_grid)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
